/* ntm_matrix_cosine_similarity.f */
verilog/ntm_cos_pkg.sv
verilog/ntm_pair_input.sv
verilog/ntm_mod_mac.sv
verilog/ntm_mod_inverse.sv
verilog/ntm_cos_output.sv
verilog/ntm_matrix_cosine_similarity.sv
test/ntm_matrix_cosine_similarity_tb.sv

/* Makefile */
# Verilator flow for the cosine similarity block
VERILATOR ?= verilator
TOP       ?= ntm_matrix_cosine_similarity_tb
FILELIST  ?= ntm_matrix_cosine_similarity.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Verdict comes from the log, not the exit code
run: compile
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST OK" $(LOG); then echo "Simulation ended without a verdict"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* test/ntm_matrix_cosine_similarity_tb.sv */
// Testbench for the row-wise squared cosine similarity block
// Random jobs from a fixed-seed LCG are checked against a software model
// Row lengths stay at or above MIN_LENGTH as the DUT requires
// Latency is counted in clock edges from the sampled last element to result_valid
`timescale 1ns/100ps

module ntm_matrix_cosine_similarity_tb;

  localparam int DW = ntm_cos_pkg::DATA_W;
  localparam int SW = ntm_cos_pkg::SIZE_W;
  localparam longint P = longint'(ntm_cos_pkg::MOD_P);
  localparam int NUM_JOBS = 12;
  localparam int MAX_ROWS = 6;
  localparam int MAX_LEN  = 40;
  localparam int MAX_GAP  = 3;
  // Worst case per job is a full gap before every element plus start and stray cycles
  localparam int JOB_CYCLES = MAX_ROWS * MAX_LEN * (MAX_GAP + 1) + 16;
  localparam int WATCHDOG_CYCLES = 20 + NUM_JOBS * JOB_CYCLES + ntm_cos_pkg::OUT_LATENCY + 16;

  logic          CLK;
  logic          RST;
  logic          start;
  logic [SW-1:0] rows;
  logic [SW-1:0] length;
  logic          in_valid;
  logic [DW-1:0] data_a;
  logic [DW-1:0] data_b;
  logic          result_valid;
  logic [DW-1:0] result;
  logic [SW-1:0] row_index;
  logic          done;
  logic          busy;

  // Marks the element that closes a row and travels with in_valid
  logic          drv_last;
  logic          started;
  int unsigned   lcg_state = 1997;
  longint        cycle = 0;
  longint        exp_result[$];
  int            exp_index[$];
  bit            exp_done[$];
  longint        end_q[$];
  logic [DW-1:0] row_a[MAX_LEN];
  logic [DW-1:0] row_b[MAX_LEN];

  ntm_matrix_cosine_similarity ntm_matrix_cosine_similarity_i (
    .CLK(CLK), .RST(RST),
    .start(start), .rows(rows), .length(length),
    .in_valid(in_valid), .data_a(data_a), .data_b(data_b),
    .result_valid(result_valid), .result(result),
    .row_index(row_index), .done(done), .busy(busy)
  );

  initial CLK = 1'b0;
  always #2 CLK = ~CLK;

  //////////////////////////////////////////////////
  // Random source and reference model
  //////////////////////////////////////////////////

  // Numerical Recipes LCG with the upper bits used
  function automatic int unsigned lcg_draw(input int unsigned span);
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return (lcg_state >> 16) % span;
  endfunction

  // Mostly full range and sometimes the band at or above the modulus
  function automatic logic [DW-1:0] draw_operand();
    if (lcg_draw(8) == 0) begin
      return DW'(ntm_cos_pkg::MOD_P + lcg_draw(15));
    end
    return DW'(lcg_draw(65536));
  endfunction

  function automatic longint pow_mod(input longint b, input longint e);
    longint r;
    longint x;
    longint k;
    r = 1;
    x = b % P;
    k = e;
    while (k > 0) begin
      if (k % 2 == 1) begin
        r = (r * x) % P;
      end
      x = (x * x) % P;
      k = k / 2;
    end
    return r;
  endfunction

  // dot^2 / (|a|^2 |b|^2) mod P with the inverse of 0 taken as 0
  function automatic longint row_cosine(input int n_len);
    longint dot;
    longint na;
    longint nb;
    longint ra;
    longint rb;
    longint den;
    dot = 0;
    na = 0;
    nb = 0;
    for (int e = 0; e < n_len; e++) begin
      ra = longint'(row_a[e]) % P;
      rb = longint'(row_b[e]) % P;
      dot = (dot + ra * rb) % P;
      na = (na + ra * ra) % P;
      nb = (nb + rb * rb) % P;
    end
    den = (na * nb) % P;
    return (((dot * dot) % P) * pow_mod(den, P - 2)) % P;
  endfunction

  task automatic check_value(input string name, input longint got, input longint expected);
    if (got != expected) begin
      $display("error at time %0t: %s is %0d, expected %0d", $time, name, got, expected);
      $display("TEST FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  // in_valid while idle that the DUT must drop
  task automatic stray_strobes(input int count);
    repeat (count) begin
      in_valid <= 1'b1;
      data_a   <= draw_operand();
      data_b   <= draw_operand();
      drv_last <= 1'b0;
      @(posedge CLK);
    end
    in_valid <= 1'b0;
  endtask

  task automatic run_job(input int n_rows, input int n_len);
    int idx;
    int ghost_at;
    int gap;
    int zsel;
    start    <= 1'b1;
    rows     <= SW'(n_rows);
    length   <= SW'(n_len);
    started  <= 1'b1;
    @(posedge CLK);
    start    <= 1'b0;
    idx      = 0;
    // One extra start somewhere inside the job
    ghost_at = 1 + int'(lcg_draw(n_rows * n_len - 1));
    for (int r = 0; r < n_rows; r++) begin
      zsel = int'(lcg_draw(6));
      for (int e = 0; e < n_len; e++) begin
        row_a[e] = (zsel == 0) ? '0 : draw_operand();
        row_b[e] = (zsel == 1) ? '0 : draw_operand();
      end
      exp_result.push_back(row_cosine(n_len));
      exp_index.push_back(r);
      exp_done.push_back(r == n_rows - 1);
      for (int e = 0; e < n_len; e++) begin
        gap = int'(lcg_draw(8));
        // Idle gaps of 1 to 3 cycles but back to back most of the time
        if (gap >= 5) begin
          repeat (gap - 4) begin
            in_valid <= 1'b0;
            start    <= 1'b0;
            drv_last <= 1'b0;
            @(posedge CLK);
          end
        end
        in_valid <= 1'b1;
        data_a   <= row_a[e];
        data_b   <= row_b[e];
        drv_last <= (e == n_len - 1);
        start    <= (idx == ghost_at);
        if (idx == ghost_at) begin
          rows   <= SW'(lcg_draw(256));
          length <= SW'(lcg_draw(256));
        end
        idx++;
        @(posedge CLK);
      end
    end
    in_valid <= 1'b0;
    drv_last <= 1'b0;
    start    <= 1'b0;
    // Busy drops on the edge that samples the last element
    check_value("busy", longint'(busy), 1);
    @(posedge CLK);
    check_value("busy", longint'(busy), 0);
    stray_strobes(1 + int'(lcg_draw(4)));
  endtask

  //////////////////////////////////////////////////
  // Monitor, watchdog and main sequence
  //////////////////////////////////////////////////

  always @(posedge CLK) begin
    cycle = cycle + 1;
    if (in_valid && drv_last) begin
      end_q.push_back(cycle);
    end
    // Quiet outputs until the first job
    if (!started) begin
      check_value("busy", longint'(busy), 0);
      check_value("result_valid", longint'(result_valid), 0);
    end
    if (!result_valid) begin
      check_value("done", longint'(done), 0);
    end else if (exp_result.size() == 0 || end_q.size() == 0) begin
      $display("result_valid came with no row pending");
      $display("TEST FAILED");
      $fatal(1, "unexpected result");
    end else begin
      check_value("result", longint'(result), exp_result.pop_front());
      check_value("row_index", longint'(row_index), longint'(exp_index.pop_front()));
      check_value("done", longint'(done), longint'(exp_done.pop_front()));
      check_value("result latency", cycle - end_q.pop_front(),
                  longint'(ntm_cos_pkg::OUT_LATENCY));
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    $display("watchdog expired after %0d cycles with results still pending", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $fatal(1, "timeout");
  end

  initial begin
    RST      <= 1'b1;
    start    <= 1'b0;
    rows     <= '0;
    length   <= '0;
    in_valid <= 1'b0;
    data_a   <= '0;
    data_b   <= '0;
    drv_last <= 1'b0;
    started  <= 1'b0;
    repeat (10) @(posedge CLK);
    RST <= 1'b0;
    repeat (4) @(posedge CLK);
    stray_strobes(3);
    repeat (4) @(posedge CLK);
    for (int j = 0; j < NUM_JOBS; j++) begin
      run_job(1 + int'(lcg_draw(MAX_ROWS)),
              ntm_cos_pkg::MIN_LENGTH + int'(lcg_draw(MAX_LEN - ntm_cos_pkg::MIN_LENGTH + 1)));
    end
    while (exp_result.size() != 0) begin
      @(posedge CLK);
    end
    // Room for any spurious late strobe
    repeat (ntm_cos_pkg::OUT_LATENCY) @(posedge CLK);
    $display("TEST OK");
    $finish;
  end

endmodule

/* verilog/ntm_matrix_cosine_similarity.sv */
// Row-wise squared cosine similarity of two matrices, mod 65521
// One start per job; element pairs follow row by row as strobes
// Row length at least MIN_LENGTH, at most one pair per cycle
// result_valid comes OUT_LATENCY cycles after a row's last pair
`timescale 1ns/100ps

module ntm_matrix_cosine_similarity (
  input  logic                              CLK,
  input  logic                              RST,
  input  logic                              start,
  input  logic [ntm_cos_pkg::SIZE_W-1:0]    rows,
  input  logic [ntm_cos_pkg::SIZE_W-1:0]    length,
  input  logic                              in_valid,
  input  logic [ntm_cos_pkg::DATA_W-1:0]    data_a,
  input  logic [ntm_cos_pkg::DATA_W-1:0]    data_b,
  output logic                              result_valid,
  output logic [ntm_cos_pkg::DATA_W-1:0]    result,
  output logic [ntm_cos_pkg::SIZE_W-1:0]    row_index,
  output logic                              done,
  output logic                              busy
);

  // Input side to MAC
  logic                           pair_valid;
  logic [ntm_cos_pkg::DATA_W-1:0] pair_a;
  logic [ntm_cos_pkg::DATA_W-1:0] pair_b;
  logic                           row_last;
  logic                           job_last;
  // MAC to output side
  logic                           sums_valid;
  logic [ntm_cos_pkg::DATA_W-1:0] dot_sum;
  logic [ntm_cos_pkg::DATA_W-1:0] norm_a_sum;
  logic [ntm_cos_pkg::DATA_W-1:0] norm_b_sum;
  logic                           sums_job_last;

  ntm_pair_input ntm_pair_input_i (
    .CLK(CLK), .RST(RST),
    .start(start), .rows(rows), .length(length),
    .in_valid(in_valid), .data_a(data_a), .data_b(data_b),
    .pair_valid(pair_valid), .pair_a(pair_a), .pair_b(pair_b),
    .row_last(row_last), .job_last(job_last), .busy(busy)
  );

  ntm_mod_mac ntm_mod_mac_i (
    .CLK(CLK), .RST(RST),
    .pair_valid(pair_valid), .pair_a(pair_a), .pair_b(pair_b),
    .row_last(row_last), .job_last(job_last),
    .sums_valid(sums_valid), .dot_sum(dot_sum),
    .norm_a_sum(norm_a_sum), .norm_b_sum(norm_b_sum),
    .sums_job_last(sums_job_last)
  );

  ntm_cos_output ntm_cos_output_i (
    .CLK(CLK), .RST(RST),
    .sums_valid(sums_valid), .dot_sum(dot_sum),
    .norm_a_sum(norm_a_sum), .norm_b_sum(norm_b_sum),
    .sums_job_last(sums_job_last),
    .result_valid(result_valid), .result(result),
    .row_index(row_index), .done(done)
  );

endmodule

/* verilog/ntm_cos_output.sv */
// Output side: squared cosine = dot^2 * inv(|a|^2 |b|^2) mod P
// Holds one row at a time; the next sums_valid must come at least
// MIN_LENGTH cycles later so num and the job flag are still held
// Zero denominator gives result 0 through the inverse
`timescale 1ns/100ps

module ntm_cos_output (
  input  logic                              CLK,
  input  logic                              RST,
  input  logic                              sums_valid,
  input  logic [ntm_cos_pkg::DATA_W-1:0]    dot_sum,
  input  logic [ntm_cos_pkg::DATA_W-1:0]    norm_a_sum,
  input  logic [ntm_cos_pkg::DATA_W-1:0]    norm_b_sum,
  input  logic                              sums_job_last,
  output logic                              result_valid,
  output logic [ntm_cos_pkg::DATA_W-1:0]    result,
  output logic [ntm_cos_pkg::SIZE_W-1:0]    row_index,
  output logic                              done
);

  // Numerator and denominator of the pending row
  logic [ntm_cos_pkg::DATA_W-1:0] num_q;
  logic [ntm_cos_pkg::DATA_W-1:0] den_q;
  logic                           inv_start;
  logic                           inv_done;
  logic [ntm_cos_pkg::DATA_W-1:0] inv_result;
  // Pending row closes the job
  logic                           last_q;
  logic [ntm_cos_pkg::SIZE_W-1:0] row_cnt;

  //////////////////////////////////////////////////
  // Num/den stage
  //////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (sums_valid) begin
      num_q <= ntm_cos_pkg::mod_mul(dot_sum, dot_sum);
      den_q <= ntm_cos_pkg::mod_mul(norm_a_sum, norm_b_sum);
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      inv_start <= 1'b0;
      last_q    <= 1'b0;
      row_cnt   <= '0;
    end else begin
      // Inverse starts one cycle after the sums arrive
      inv_start <= sums_valid;
      if (sums_valid) begin
        last_q <= sums_job_last;
      end
      // Row counter restarts once the job is done
      if (inv_done) begin
        row_cnt <= last_q ? '0 : row_cnt + 1'b1;
      end
    end
  end

  ntm_mod_inverse ntm_mod_inverse_i (
    .CLK         (CLK),
    .RST         (RST),
    .inv_start   (inv_start),
    .inv_operand (den_q),
    .inv_done    (inv_done),
    .inv_result  (inv_result)
  );

  //////////////////////////////////////////////////
  // Result
  //////////////////////////////////////////////////

  // Final multiply in the inv_done cycle keeps OUT_LATENCY
  assign result_valid = inv_done;
  assign result       = ntm_cos_pkg::mod_mul(num_q, inv_result);
  assign row_index    = row_cnt;
  assign done         = inv_done & last_q;

endmodule

/* verilog/ntm_mod_inverse.sv */
// Modular inverse by Fermat: x^(P-2) mod P
// Fixed latency INV_LATENCY from inv_start to inv_done
// An operand of 0 yields 0; a new start restarts the walk
`timescale 1ns/100ps

module ntm_mod_inverse (
  input  logic                              CLK,
  input  logic                              RST,
  input  logic                              inv_start,
  input  logic [ntm_cos_pkg::DATA_W-1:0]    inv_operand,
  output logic                              inv_done,
  output logic [ntm_cos_pkg::DATA_W-1:0]    inv_result
);

  localparam int CNT_W = $clog2(ntm_cos_pkg::EXP_W);

  // Running square x^(2^k)
  logic [ntm_cos_pkg::DATA_W-1:0] base;
  // Product of the squares whose exponent bit is set
  logic [ntm_cos_pkg::DATA_W-1:0] acc;
  logic [CNT_W-1:0]               bit_idx;
  logic                           running;
  logic                           last_step;

  assign last_step  = (bit_idx == CNT_W'(ntm_cos_pkg::EXP_W - 1));
  assign inv_result = acc;

  //////////////////////////////////////////////////
  // Bit walk control
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      running  <= 1'b0;
      inv_done <= 1'b0;
      bit_idx  <= '0;
    end else begin
      inv_done <= running & last_step;
      if (inv_start) begin
        running <= 1'b1;
        bit_idx <= '0;
      end else if (running) begin
        bit_idx <= bit_idx + 1'b1;
        if (last_step) begin
          running <= 1'b0;
        end
      end
    end
  end

  // Square-and-multiply datapath, LSB first
  always_ff @(posedge CLK) begin
    if (inv_start) begin
      base <= inv_operand;
      acc  <= ntm_cos_pkg::DATA_W'(1);
    end else if (running) begin
      if (ntm_cos_pkg::INV_EXP[bit_idx]) begin
        acc <= ntm_cos_pkg::mod_mul(acc, base);
      end
      base <= ntm_cos_pkg::mod_mul(base, base);
    end
  end

endmodule

/* verilog/ntm_mod_mac.sv */
// Three modular multiply-accumulators: a.b, a.a and b.b per row
// Inputs must already be residues below MOD_P
// Sums are valid only while sums_valid is high; the next row
// may start in that same cycle with no bubble
`timescale 1ns/100ps

module ntm_mod_mac (
  input  logic                              CLK,
  input  logic                              RST,
  input  logic                              pair_valid,
  input  logic [ntm_cos_pkg::DATA_W-1:0]    pair_a,
  input  logic [ntm_cos_pkg::DATA_W-1:0]    pair_b,
  input  logic                              row_last,
  input  logic                              job_last,
  output logic                              sums_valid,
  output logic [ntm_cos_pkg::DATA_W-1:0]    dot_sum,
  output logic [ntm_cos_pkg::DATA_W-1:0]    norm_a_sum,
  output logic [ntm_cos_pkg::DATA_W-1:0]    norm_b_sum,
  output logic                              sums_job_last
);

  // Per-element products, already reduced
  logic [ntm_cos_pkg::DATA_W-1:0] prod_ab;
  logic [ntm_cos_pkg::DATA_W-1:0] prod_aa;
  logic [ntm_cos_pkg::DATA_W-1:0] prod_bb;
  // Next pair opens a new row
  logic                           fresh;

  assign prod_ab = ntm_cos_pkg::mod_mul(pair_a, pair_b);
  assign prod_aa = ntm_cos_pkg::mod_mul(pair_a, pair_a);
  assign prod_bb = ntm_cos_pkg::mod_mul(pair_b, pair_b);

  //////////////////////////////////////////////////
  // Row framing
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      sums_valid    <= 1'b0;
      sums_job_last <= 1'b0;
      fresh         <= 1'b1;
    end else begin
      sums_valid    <= pair_valid & row_last;
      sums_job_last <= pair_valid & row_last & job_last;
      // Idle gaps keep the flag as it is
      if (pair_valid) begin
        fresh <= row_last;
      end
    end
  end

  //////////////////////////////////////////////////
  // Accumulators
  //////////////////////////////////////////////////

  // Accumulators double as the sums outputs
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      dot_sum    <= '0;
      norm_a_sum <= '0;
      norm_b_sum <= '0;
    end else if (pair_valid) begin
      if (fresh) begin
        // First element of a row overwrites the old sums
        dot_sum    <= prod_ab;
        norm_a_sum <= prod_aa;
        norm_b_sum <= prod_bb;
      end else begin
        dot_sum    <= ntm_cos_pkg::mod_add(dot_sum, prod_ab);
        norm_a_sum <= ntm_cos_pkg::mod_add(norm_a_sum, prod_aa);
        norm_b_sum <= ntm_cos_pkg::mod_add(norm_b_sum, prod_bb);
      end
    end
  end

endmodule

/* verilog/ntm_pair_input.sv */
// Input side of the cosine similarity block
// rows and length must both be at least 1, length at least MIN_LENGTH
// in_valid in the same cycle as start is not part of the job
// At most one element pair per cycle, no back-pressure
`timescale 1ns/100ps

module ntm_pair_input (
  input  logic                              CLK,
  input  logic                              RST,
  input  logic                              start,
  input  logic [ntm_cos_pkg::SIZE_W-1:0]    rows,
  input  logic [ntm_cos_pkg::SIZE_W-1:0]    length,
  input  logic                              in_valid,
  input  logic [ntm_cos_pkg::DATA_W-1:0]    data_a,
  input  logic [ntm_cos_pkg::DATA_W-1:0]    data_b,
  output logic                              pair_valid,
  output logic [ntm_cos_pkg::DATA_W-1:0]    pair_a,
  output logic [ntm_cos_pkg::DATA_W-1:0]    pair_b,
  output logic                              row_last,
  output logic                              job_last,
  output logic                              busy
);

  // Latched job sizes
  logic [ntm_cos_pkg::SIZE_W-1:0] rows_q;
  logic [ntm_cos_pkg::SIZE_W-1:0] length_q;
  // Position inside the job
  logic [ntm_cos_pkg::SIZE_W-1:0] elem_cnt;
  logic [ntm_cos_pkg::SIZE_W-1:0] row_cnt;
  logic                           accept;
  logic                           elem_end;
  logic                           row_end;

  assign accept   = busy & in_valid;
  assign elem_end = (elem_cnt == length_q - 1'b1);
  assign row_end  = (row_cnt == rows_q - 1'b1);

  //////////////////////////////////////////////////
  // Job control and end tagging
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy       <= 1'b0;
      pair_valid <= 1'b0;
      row_last   <= 1'b0;
      job_last   <= 1'b0;
      rows_q     <= '0;
      length_q   <= '0;
      elem_cnt   <= '0;
      row_cnt    <= '0;
    end else begin
      pair_valid <= accept;
      row_last   <= accept & elem_end;
      job_last   <= accept & elem_end & row_end;
      // Start only counts while idle
      if (!busy && start) begin
        rows_q   <= rows;
        length_q <= length;
        elem_cnt <= '0;
        row_cnt  <= '0;
        busy     <= 1'b1;
      end else if (accept) begin
        if (elem_end) begin
          elem_cnt <= '0;
          row_cnt  <= row_end ? '0 : row_cnt + 1'b1;
          // Last element of last row closes the job
          if (row_end) begin
            busy <= 1'b0;
          end
        end else begin
          elem_cnt <= elem_cnt + 1'b1;
        end
      end
    end
  end

  // Operand registers, reduced on the way in
  always_ff @(posedge CLK) begin
    if (accept) begin
      pair_a <= ntm_cos_pkg::mod_reduce(data_a);
      pair_b <= ntm_cos_pkg::mod_reduce(data_b);
    end
  end

endmodule

/* verilog/ntm_cos_pkg.sv */
// Shared constants and modular helpers for the cosine similarity datapath
// The modulus is fixed at build time; there is no run-time modulus
// All operands are unsigned residues below MOD_P once reduced
package ntm_cos_pkg;

  //////////////////////////////////////////////////
  // Widths and modulus
  //////////////////////////////////////////////////

  localparam int DATA_W = 16;
  localparam int SIZE_W = 8;
  localparam int EXP_W  = 16;
  localparam int unsigned MOD_P = 65521;

  // Fermat exponent, P-2
  localparam logic [EXP_W-1:0] INV_EXP = EXP_W'(MOD_P - 2);

  //////////////////////////////////////////////////
  // Limits and latencies
  //////////////////////////////////////////////////

  // Rows shorter than this would overrun the output side
  localparam int MIN_LENGTH  = 24;
  // One load cycle plus one cycle per exponent bit
  localparam int INV_LATENCY = EXP_W + 1;
  // Input reg, MAC reg, num/den reg, then the inverse
  localparam int OUT_LATENCY = INV_LATENCY + 3;

  // Product of two residues, reduced
  function automatic logic [DATA_W-1:0] mod_mul(input logic [DATA_W-1:0] x,
                                                input logic [DATA_W-1:0] y);
    logic [2*DATA_W-1:0] prod;
    prod = x * y;
    return DATA_W'(prod % MOD_P);
  endfunction

  // Sum of two residues, one conditional subtract
  function automatic logic [DATA_W-1:0] mod_add(input logic [DATA_W-1:0] x,
                                                input logic [DATA_W-1:0] y);
    logic [DATA_W:0] sum;
    sum = {1'b0, x} + {1'b0, y};
    if (sum >= MOD_P) begin
      sum = (DATA_W+1)'(sum - MOD_P);
    end
    return sum[DATA_W-1:0];
  endfunction

  // Raw 16-bit value into range, at most one subtract needed
  function automatic logic [DATA_W-1:0] mod_reduce(input logic [DATA_W-1:0] x);
    return (x >= MOD_P) ? DATA_W'(x - MOD_P) : x;
  endfunction

endpackage
